/* command_cfg.svh */
`ifndef COMMAND_CFG_SVH
`define COMMAND_CFG_SVH

//////////////////////
// command field widths
//////////////////////

// host physical address
`define CMD_ADDR_W 64

// one tag per outstanding command
`define CMD_TAG_W 8

// transfer size in bytes
`define CMD_SIZE_W 12

//////////////////////
// issue path sizing
//////////////////////

`define CMD_QUEUE_DEPTH 4 // entries per source queue

// command credits granted by the host at reset
`define CMD_CREDITS 8

`endif

/* command_pkg.sv */
`include "command_cfg.svh"

package command_pkg;

  //////////////////////
  // field types
  //////////////////////

  typedef logic [`CMD_ADDR_W-1:0] cmd_addr_t;
  typedef logic [`CMD_TAG_W-1:0]  cmd_tag_t;
  typedef logic [`CMD_SIZE_W-1:0] cmd_size_t;

  // must reach CMD_CREDITS itself, hence the +1
  typedef logic [$clog2(`CMD_CREDITS + 1)-1:0] credit_count_t;

  // command codes toward the host
  typedef enum logic [2:0] {
    INVALID    = 3'd0,
    READ_CL_NA = 3'd1, // read, no allocate
    WRITE_NA   = 3'd2, // write, no allocate
    READ_CL_S  = 3'd3, // read shared
    RESTART    = 3'd4
  } command_type_t;

  localparam cmd_tag_t INVALID_TAG = '1;

  //////////////////////
  // command line
  //////////////////////

  typedef struct packed {
    logic          valid;
    command_type_t command;
    cmd_addr_t     address;
    cmd_tag_t      tag;
    cmd_size_t     size;
  } command_buffer_line_t;

  //////////////////////
  // arbiter structs
  //////////////////////

  // one bit per source, wed has the highest priority
  typedef struct packed {
    logic wed;
    logic write;
    logic read;
    logic restart;
  } arbiter_request_t;

  typedef struct packed {
    command_buffer_line_t command_out; // registered winner
    logic                 wed_ready;
    logic                 write_ready;
    logic                 read_ready;
    logic                 restart_ready;
  } arbiter_out_t;

endpackage

/* command_queue.sv */
`timescale 1ns/1ns
`include "command_cfg.svh"

module command_queue (
  input  logic                              clock,
  input  logic                              rstn,
  input  command_pkg::command_buffer_line_t push_line,
  output logic                              in_ready,
  input  logic                              pop,
  output command_pkg::command_buffer_line_t head_line,
  output logic                              request
);

  localparam int DEPTH = `CMD_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  command_pkg::command_buffer_line_t entries [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             empty;
  logic             full;
  logic             do_push;
  logic             do_pop;

  // wraps at DEPTH, works for depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] result;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      result = '0;
    end else begin
      result = ptr + 1'b1;
    end
    return result;
  endfunction

  assign empty    = (count == '0);
  assign full     = (count == CNT_W'(DEPTH));
  assign in_ready = ~full;
  assign request  = ~empty; // head waits for a grant
  assign do_push  = push_line.valid & ~full;
  assign do_pop   = pop & ~empty;

  //////////////////////
  // pointers and count
  //////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // idle, or push and pop together
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) entries[wr_ptr] <= push_line;
  end

  // head is only meaningful while something is stored
  always_comb begin
    head_line       = entries[rd_ptr];
    head_line.valid = ~empty;
  end

endmodule

/* command_buffer_arbiter.sv */
`timescale 1ns/1ns

module command_buffer_arbiter (
  input  logic                              clock,
  input  logic                              rstn,
  input  logic                              issue_enable,
  input  command_pkg::arbiter_request_t     requests,
  input  command_pkg::command_buffer_line_t wed_line,
  input  command_pkg::command_buffer_line_t write_line,
  input  command_pkg::command_buffer_line_t read_line,
  input  command_pkg::command_buffer_line_t restart_line,
  output command_pkg::arbiter_out_t         arbiter_out,
  output logic                              pop_any
);

  localparam command_pkg::command_buffer_line_t INVALID_LINE = '{
    valid:   1'b0,
    command: command_pkg::INVALID,
    address: '0,
    tag:     command_pkg::INVALID_TAG,
    size:    '0
  };

  command_pkg::arbiter_request_t     grant;
  command_pkg::command_buffer_line_t selected_line;
  command_pkg::command_buffer_line_t command_q;

  //////////////////////
  // fixed priority grant
  //////////////////////

  // wed > write > read > restart, nothing without a credit
  always_comb begin
    grant = '0;
    if (issue_enable) begin
      if (requests.wed) begin
        grant.wed = 1'b1;
      end else if (requests.write) begin
        grant.write = 1'b1;
      end else if (requests.read) begin
        grant.read = 1'b1;
      end else if (requests.restart) begin
        grant.restart = 1'b1;
      end
    end
  end

  // winner head line
  always_comb begin
    if (grant.wed) begin
      selected_line = wed_line;
    end else if (grant.write) begin
      selected_line = write_line;
    end else if (grant.read) begin
      selected_line = read_line;
    end else if (grant.restart) begin
      selected_line = restart_line;
    end else begin
      selected_line = INVALID_LINE;
    end
  end

  assign pop_any = grant.wed | grant.write | grant.read | grant.restart;

  //////////////////////
  // registered command out
  //////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      command_q <= INVALID_LINE;
    end else begin
      command_q <= selected_line; // invalid line when nothing granted
    end
  end

  assign arbiter_out.command_out   = command_q;
  assign arbiter_out.wed_ready     = grant.wed; // pops the queue this edge
  assign arbiter_out.write_ready   = grant.write;
  assign arbiter_out.read_ready    = grant.read;
  assign arbiter_out.restart_ready = grant.restart;

endmodule

/* command_credit_tracker.sv */
`timescale 1ns/1ns
`include "command_cfg.svh"

module command_credit_tracker (
  input  logic                       clock,
  input  logic                       rstn,
  input  logic                       enable,
  input  logic                       pop_any,
  input  logic                       credit_return,
  output logic                       issue_enable,
  output command_pkg::credit_count_t credits
);

  localparam command_pkg::credit_count_t MAX_CREDITS =
    command_pkg::credit_count_t'(`CMD_CREDITS);
  localparam command_pkg::credit_count_t ONE_CREDIT = command_pkg::credit_count_t'(1);

  command_pkg::credit_count_t count_q;
  logic                       at_max;
  logic                       accept_return;

  //////////////////////
  // credit counter
  //////////////////////

  assign at_max        = (count_q == MAX_CREDITS);
  assign accept_return = credit_return & ~at_max; // host cannot exceed its grant

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      count_q <= MAX_CREDITS;
    end else begin
      // pop together with a return leaves the count alone
      if (pop_any && !credit_return) begin
        count_q <= count_q - ONE_CREDIT;
      end else if (accept_return && !pop_any) begin
        count_q <= count_q + ONE_CREDIT;
      end
    end
  end

  //////////////////////
  // issue gate
  //////////////////////

  // count of this cycle gates the grant, update lands next edge
  assign issue_enable = enable & (count_q != '0);
  assign credits      = count_q;

endmodule

/* command_issue_top.sv */
`timescale 1ns/1ns

module command_issue_top (
  input  logic                              clock,
  input  logic                              rstn,
  input  logic                              enable,
  input  logic                              credit_return,
  input  command_pkg::command_buffer_line_t wed_in,
  input  command_pkg::command_buffer_line_t write_in,
  input  command_pkg::command_buffer_line_t read_in,
  input  command_pkg::command_buffer_line_t restart_in,
  output logic                              wed_ready,
  output logic                              write_ready,
  output logic                              read_ready,
  output logic                              restart_ready,
  output command_pkg::command_buffer_line_t command_out,
  output command_pkg::credit_count_t        credits
);

  command_pkg::arbiter_request_t     requests;
  command_pkg::arbiter_out_t         arbiter_out;
  command_pkg::command_buffer_line_t wed_head;
  command_pkg::command_buffer_line_t write_head;
  command_pkg::command_buffer_line_t read_head;
  command_pkg::command_buffer_line_t restart_head;
  logic                              issue_enable;
  logic                              pop_any;

  //////////////////////
  // source queues
  //////////////////////

  command_queue wed_queue (
    .clock, .rstn,
    .push_line (wed_in),
    .in_ready  (wed_ready),
    .pop       (arbiter_out.wed_ready),
    .head_line (wed_head),
    .request   (requests.wed)
  );

  command_queue write_queue (
    .clock, .rstn,
    .push_line (write_in),
    .in_ready  (write_ready),
    .pop       (arbiter_out.write_ready),
    .head_line (write_head),
    .request   (requests.write)
  );

  command_queue read_queue (
    .clock, .rstn,
    .push_line (read_in),
    .in_ready  (read_ready),
    .pop       (arbiter_out.read_ready),
    .head_line (read_head),
    .request   (requests.read)
  );

  command_queue restart_queue (
    .clock, .rstn,
    .push_line (restart_in),
    .in_ready  (restart_ready),
    .pop       (arbiter_out.restart_ready),
    .head_line (restart_head),
    .request   (requests.restart)
  );

  //////////////////////
  // arbiter and credits
  //////////////////////

  command_buffer_arbiter arbiter (
    .clock, .rstn,
    .issue_enable (issue_enable),
    .requests     (requests),
    .wed_line     (wed_head),
    .write_line   (write_head),
    .read_line    (read_head),
    .restart_line (restart_head),
    .arbiter_out  (arbiter_out),
    .pop_any      (pop_any)
  );

  command_credit_tracker credit_tracker (
    .clock, .rstn,
    .enable        (enable),
    .pop_any       (pop_any),
    .credit_return (credit_return),
    .issue_enable  (issue_enable),
    .credits       (credits)
  );

  assign command_out = arbiter_out.command_out; // one command per cycle, no back-pressure

endmodule

/* command_checker.sv */
`timescale 1ns/1ns
`include "command_cfg.svh"

module command_checker (
  input  logic                              clock,
  input  logic                              rstn,
  input  logic                              enable,
  input  logic                              credit_return,
  input  command_pkg::command_buffer_line_t wed_in,
  input  command_pkg::command_buffer_line_t write_in,
  input  command_pkg::command_buffer_line_t read_in,
  input  command_pkg::command_buffer_line_t restart_in,
  input  logic                              wed_ready,
  input  logic                              write_ready,
  input  logic                              read_ready,
  input  logic                              restart_ready,
  input  command_pkg::command_buffer_line_t command_out,
  input  command_pkg::credit_count_t        credits,
  output int                                error_count,
  output int                                pushed_count,
  output int                                issued_count
);

  localparam int DEPTH       = `CMD_QUEUE_DEPTH;
  localparam int MAX_CREDITS = `CMD_CREDITS;

  command_pkg::command_buffer_line_t model_q [4][$]; // index 0 is wed, the highest priority
  command_pkg::command_buffer_line_t in_lines [4];
  command_pkg::command_buffer_line_t expected_out;  // what command_out shows after this edge
  logic [3:0]                        ready_vec;
  int                                model_credits;
  int                                errors = 0;
  int                                pushes = 0;
  int                                issues = 0;

  assign in_lines[0] = wed_in;
  assign in_lines[1] = write_in;
  assign in_lines[2] = read_in;
  assign in_lines[3] = restart_in;
  assign ready_vec   = {restart_ready, read_ready, write_ready, wed_ready};

  // host side line while nothing issues
  function automatic command_pkg::command_buffer_line_t idle_line();
    command_pkg::command_buffer_line_t line;
    line.valid   = 1'b0;
    line.command = command_pkg::INVALID;
    line.address = '0;
    line.tag     = command_pkg::INVALID_TAG;
    line.size    = '0;
    return line;
  endfunction

  function automatic string source_name(input int index);
    string name;
    case (index)
      0:       name = "wed";
      1:       name = "write";
      2:       name = "read";
      default: name = "restart";
    endcase
    return name;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("ERROR time %0t %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  //////////////////////
  // model step per edge
  //////////////////////

  always @(posedge clock) begin
    int sizes [4];
    int winner;
    if (!rstn) begin
      for (int i = 0; i < 4; i++) model_q[i].delete();
      model_credits = MAX_CREDITS;
      expected_out  = idle_line();
    end else begin
      check_value("command_out.valid", 64'(expected_out.valid), 64'(command_out.valid));
      check_value("command_out.command", 64'(expected_out.command), 64'(command_out.command));
      check_value("command_out.address", 64'(expected_out.address), 64'(command_out.address));
      check_value("command_out.tag", 64'(expected_out.tag), 64'(command_out.tag));
      check_value("command_out.size", 64'(expected_out.size), 64'(command_out.size));
      check_value("credits", 64'(model_credits), 64'(credits));
      if (command_out.valid) issues++;
      for (int i = 0; i < 4; i++) begin
        sizes[i] = model_q[i].size();
        check_value({source_name(i), "_ready"}, 64'(sizes[i] < DEPTH), 64'(ready_vec[i]));
      end
      // first non-empty queue wins while a credit is left
      winner = -1;
      if (enable && model_credits > 0) begin
        for (int i = 0; i < 4; i++) begin
          if (winner < 0 && sizes[i] > 0) winner = i;
        end
      end
      if (winner >= 0) expected_out = model_q[winner].pop_front();
      else             expected_out = idle_line();
      for (int i = 0; i < 4; i++) begin
        if (in_lines[i].valid && sizes[i] < DEPTH) begin // full check uses the count before the edge
          model_q[i].push_back(in_lines[i]);
          pushes++;
        end
      end
      if (winner >= 0 && !credit_return) begin
        model_credits--;
      end else if (winner < 0 && credit_return && model_credits < MAX_CREDITS) begin
        model_credits++;
      end
    end
    error_count  <= errors;
    pushed_count <= pushes;
    issued_count <= issues;
  end

endmodule

/* tb_command_issue.sv */
`timescale 1ns/1ns
`include "command_cfg.svh"

module tb_command_issue;

  localparam int RESET_CYCLES  = 16;
  localparam int DRAIN_TIMEOUT = 2000;
  localparam int MAX_GAP       = 3; // 0 to 2 idle cycles between file lines

  logic                              clock;
  logic                              rstn;
  logic                              enable;
  logic                              credit_return;
  command_pkg::command_buffer_line_t source_line [4]; // wed, write, read, restart
  command_pkg::command_buffer_line_t next_lines [4];
  logic                              wed_ready;
  logic                              write_ready;
  logic                              read_ready;
  logic                              restart_ready;
  logic [3:0]                        ready_vec;
  command_pkg::command_buffer_line_t command_out;
  command_pkg::credit_count_t        credits;
  int                                error_count;
  int                                pushed_count;
  int                                issued_count;
  int                                other_errors = 0;
  int                                refused = 0;

  assign ready_vec = {restart_ready, read_ready, write_ready, wed_ready};

  command_issue_top dut (
    .clock, .rstn, .enable, .credit_return,
    .wed_in (source_line[0]), .write_in (source_line[1]),
    .read_in (source_line[2]), .restart_in (source_line[3]),
    .wed_ready, .write_ready, .read_ready, .restart_ready,
    .command_out, .credits
  );

  command_checker issue_checker (
    .clock, .rstn, .enable, .credit_return,
    .wed_in (source_line[0]), .write_in (source_line[1]),
    .read_in (source_line[2]), .restart_in (source_line[3]),
    .wed_ready, .write_ready, .read_ready, .restart_ready,
    .command_out, .credits, .error_count, .pushed_count, .issued_count
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic command_pkg::command_buffer_line_t quiet_line();
    command_pkg::command_buffer_line_t line;
    line = '0;
    return line;
  endfunction

  // sources offer only while their queue has room
  task automatic drive_cycle(input logic en, input logic ret);
    @(posedge clock);
    enable        <= en;
    credit_return <= ret;
    for (int i = 0; i < 4; i++) begin
      if (next_lines[i].valid && ready_vec[i]) begin
        source_line[i] <= next_lines[i];
      end else begin
        if (next_lines[i].valid) refused++;
        source_line[i] <= quiet_line();
      end
      next_lines[i] = quiet_line();
    end
  endtask

  //////////////////////
  // stimulus file
  //////////////////////

  task automatic run_file();
    int          fd;
    int          fields;
    int          line_no;
    int          gap;
    int          en_v;
    int          ret_v;
    int          cmd_v [4];
    logic [63:0] addr_v [4];
    int          tag_v [4];
    int          size_v [4];
    string       text;
    line_no = 0;
    fd = $fopen("command_input.txt", "r");
    if (fd == 0) begin
      $display("could not open command_input.txt");
      other_errors++;
      return;
    end
    while (!$feof(fd)) begin
      text = "";
      void'($fgets(text, fd));
      line_no++;
      if (text.len() < 2 || text.substr(0, 0) == "#") continue;
      fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
        en_v, ret_v, cmd_v[0], addr_v[0], tag_v[0], size_v[0], cmd_v[1], addr_v[1],
        tag_v[1], size_v[1], cmd_v[2], addr_v[2], tag_v[2], size_v[2], cmd_v[3],
        addr_v[3], tag_v[3], size_v[3]);
      if (fields != 18) begin
        $display("line %0d of command_input.txt has %0d fields instead of 18", line_no, fields);
        other_errors++;
        continue;
      end
      for (int i = 0; i < 4; i++) begin
        next_lines[i].valid   = (cmd_v[i] != 0); // command 0 leaves the source idle
        next_lines[i].command = command_pkg::command_type_t'(cmd_v[i][2:0]);
        next_lines[i].address = command_pkg::cmd_addr_t'(addr_v[i]);
        next_lines[i].tag     = command_pkg::cmd_tag_t'(tag_v[i]);
        next_lines[i].size    = command_pkg::cmd_size_t'(size_v[i]);
      end
      drive_cycle(en_v[0], ret_v[0]);
      gap = int'($urandom % MAX_GAP);
      repeat (gap) drive_cycle(en_v[0], 1'b0); // credit_return only pulses
    end
    $fclose(fd);
  endtask

  initial begin
    int wait_cycles;
    void'($urandom(32'hcdd1_c710));
    rstn          = 1'b0;
    enable        = 1'b0;
    credit_return = 1'b0;
    for (int i = 0; i < 4; i++) begin
      source_line[i] = quiet_line();
      next_lines[i]  = quiet_line();
    end
    repeat (RESET_CYCLES) @(posedge clock);
    rstn <= 1'b1;
    run_file();
    // drain with credits flowing back every cycle
    repeat (2) drive_cycle(1'b1, 1'b1);
    wait_cycles = 0;
    while (issued_count != pushed_count && wait_cycles < DRAIN_TIMEOUT) begin
      drive_cycle(1'b1, 1'b1);
      wait_cycles++;
    end
    if (issued_count != pushed_count) begin
      $display("timeout while draining, %0d of %0d pushed commands were issued",
               issued_count, pushed_count);
      other_errors++;
    end
    if (pushed_count == 0) begin
      $display("no command was accepted by any queue");
      other_errors++;
    end
    repeat (4) drive_cycle(1'b1, 1'b0);
    @(negedge clock); // counts of the last edge settle
    $display("summary: %0d value errors, %0d other errors, %0d pushed, %0d issued, %0d refused",
             error_count, other_errors, pushed_count, issued_count, refused);
    if (error_count == 0 && other_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* command_input.txt */
# enable credit_return, then cmd addr tag size for wed, write, read and restart (hex)
# cmd 0 leaves that source idle, 1 read_cl_na, 2 write_na, 3 read_cl_s, 4 restart
# single sources, push order and fields kept
1 0  1 1000 01 080  0 0 0 0  0 0 0 0  0 0 0 0
1 0  1 1080 02 080  0 0 0 0  0 0 0 0  0 0 0 0
1 0  1 1100 03 040  0 0 0 0  0 0 0 0  0 0 0 0
1 1  1 1140 04 020  0 0 0 0  0 0 0 0  0 0 0 0
1 1  0 0 0 0  2 2000 10 080  0 0 0 0  0 0 0 0
1 1  0 0 0 0  2 2080 11 100  0 0 0 0  0 0 0 0
1 1  0 0 0 0  0 0 0 0  3 3000 20 080  0 0 0 0
1 1  0 0 0 0  0 0 0 0  0 0 0 0  4 4000 30 000
1 1  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0
1 1  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0
# enable low, all queues fill and the fifth offer is refused
0 0  1 1200 05 080  2 2100 12 080  3 3080 21 080  4 4040 31 000
0 0  1 1240 06 080  2 2140 13 080  3 30c0 22 080  4 4080 32 000
0 0  1 1280 07 080  2 2180 14 080  3 3100 23 080  4 40c0 33 000
0 0  1 12c0 08 080  2 21c0 15 080  3 3140 24 080  4 4100 34 000
0 0  1 1300 09 080  2 2200 16 080  3 3180 25 080  4 4140 35 000
# enable back without returns, issue stops when the credits are gone
1 0  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0
1 0  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0
1 0  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0
1 0  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0
1 0  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0
1 0  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0
# single returns, one more command each
1 1  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0
1 1  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0
1 1  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0
1 1  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0
# push during pop, returns during issue
1 1  1 1400 0a 100  0 0 0 0  3 3200 27 040  0 0 0 0
1 1  1 1440 0b 100  2 2300 18 020  0 0 0 0  0 0 0 0
1 0  1 1480 0c 100  0 0 0 0  3 3240 28 040  4 4200 37 000
1 1  0 0 0 0  2 2340 19 020  0 0 0 0  0 0 0 0
1 1  1 14c0 0d 100  0 0 0 0  0 0 0 0  0 0 0 0
1 1  0 0 0 0  0 0 0 0  3 3280 29 040  0 0 0 0
1 1  1 1500 0e 100  2 2380 1a 020  3 32c0 2a 040  4 4240 38 000
# enable drops again, then resumes
0 1  1 1540 0f 080  0 0 0 0  0 0 0 0  4 4280 39 000
0 0  0 0 0 0  2 23c0 1b 080  3 3300 2b 080  0 0 0 0
1 1  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0
1 1  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0

/* filelist.f */
+incdir+.
command_pkg.sv
command_queue.sv
command_buffer_arbiter.sv
command_credit_tracker.sv
command_issue_top.sv
command_checker.sv
tb_command_issue.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_command_issue
DUT_TOP   ?= command_issue_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= test passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
